// File: cache_config.svh
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

//////////////////////////////////////////////////
// Cache geometry
//////////////////////////////////////////////////

// Byte address width seen by both front ports
`define CACHE_ADDR_W 32

// Word width, front end and memory
`define CACHE_DATA_W 32

// Line index width, 16 lines per cache
`define CACHE_LINE_OFF_W 4

// Word offset width, 4 words per line
`define CACHE_WORD_OFF_W 2

// Tag width follows from the above
// addr_w - byte offset - line_off_w - word_off_w

`endif

// File: cache_pkg.sv
package cache_pkg;

`include "cache_config.svh"

   //////////////////////////////////////////////////
   // Vector types
   //////////////////////////////////////////////////

   typedef logic [`CACHE_DATA_W-1:0]   word_t;   // Data word
   typedef logic [`CACHE_DATA_W/8-1:0] strb_t;   // Byte enables

   // Word address, byte offset bits stripped
   typedef logic [`CACHE_ADDR_W-$clog2(`CACHE_DATA_W/8)-1:0] waddr_t;

   typedef logic [`CACHE_LINE_OFF_W-1:0] line_idx_t;  // Line select
   typedef logic [`CACHE_WORD_OFF_W-1:0] word_off_t;  // Word in line

   // Upper word address bits above index and offset
   typedef logic [`CACHE_ADDR_W-$clog2(`CACHE_DATA_W/8)
                  -`CACHE_LINE_OFF_W-`CACHE_WORD_OFF_W-1:0] tag_t;

   // L1 controller states
   typedef enum logic [1:0] {
      CACHE_IDLE,    // Waiting for a front request
      CACHE_FILL,    // Line refill, one word per beat
      CACHE_WRITE    // Single write-through beat
   } cache_state_t;

endpackage

// File: mem_bus_if.sv
`timescale 1ns/1ps

// Native valid/ready memory bus
// Request held stable until the ready pulse
interface mem_bus_if;

   logic              valid;  // Request strobe
   cache_pkg::waddr_t addr;   // Word address
   cache_pkg::word_t  wdata;  // Write data
   cache_pkg::strb_t  wstrb;  // Zero means read
   cache_pkg::word_t  rdata;  // Valid with ready on reads
   logic              ready;  // One cycle acknowledge

   // Cache side
   modport master (
      output valid, addr, wdata, wstrb,
      input  rdata, ready
   );

   // Interconnect side
   modport slave (
      input  valid, addr, wdata, wstrb,
      output rdata, ready
   );

endinterface

// File: l1_cache.sv
`timescale 1ns/1ps
`include "cache_config.svh"

// Direct-mapped write-through L1, no write allocate
module l1_cache (
   input  logic              clk,
   input  logic              i_reset,
   // Front port
   input  logic              i_valid,
   input  cache_pkg::waddr_t i_addr,
   input  cache_pkg::word_t  i_wdata,
   input  cache_pkg::strb_t  i_wstrb,
   output cache_pkg::word_t  o_rdata,
   output logic              o_ready,
   // Memory side
   mem_bus_if.master         m_bus
);

   localparam int N_LINES = 2 ** `CACHE_LINE_OFF_W;
   localparam int N_WORDS = 2 ** (`CACHE_LINE_OFF_W + `CACHE_WORD_OFF_W);
   localparam int N_BYTES = `CACHE_DATA_W / 8;

   //////////////////////////////////////////////////
   // Storage
   //////////////////////////////////////////////////

   logic [N_LINES-1:0]  valid_q;           // Line valid bits
   cache_pkg::tag_t     tag_q  [N_LINES];  // Tag per line
   cache_pkg::word_t    data_q [N_WORDS];  // Line data, idx:off

   cache_pkg::cache_state_t state_q;
   cache_pkg::word_off_t    cnt_q;         // Fill beat counter

   // Memory request registers
   logic              mem_valid_q;
   cache_pkg::waddr_t mem_addr_q;
   cache_pkg::word_t  mem_wdata_q;
   cache_pkg::strb_t  mem_wstrb_q;

   //////////////////////////////////////////////////
   // Address split and lookup
   //////////////////////////////////////////////////

   cache_pkg::tag_t      req_tag;
   cache_pkg::line_idx_t req_idx;
   cache_pkg::word_off_t req_off;

   // Front holds addr stable until ready, so it is used directly
   assign req_off = i_addr[`CACHE_WORD_OFF_W-1:0];
   assign req_idx = i_addr[`CACHE_WORD_OFF_W +: `CACHE_LINE_OFF_W];
   assign req_tag = i_addr[$bits(cache_pkg::waddr_t)-1 :
                           `CACHE_WORD_OFF_W + `CACHE_LINE_OFF_W];

   logic hit;
   logic is_write;

   assign hit      = valid_q[req_idx] && (tag_q[req_idx] == req_tag);
   assign is_write = |i_wstrb;   // Any strobe set means write

   // Decode of this cycle's events
   logic accept;
   logic rd_hit;
   logic rd_miss;
   logic wr_start;
   logic mem_ack;
   logic fill_ack;
   logic fill_last;
   logic wr_ack;

   // No accept in the ready cycle, front still shows the old valid
   assign accept    = (state_q == cache_pkg::CACHE_IDLE) && i_valid && !o_ready;
   assign rd_hit    = accept && !is_write && hit;
   assign rd_miss   = accept && !is_write && !hit;
   assign wr_start  = accept && is_write;
   assign mem_ack   = mem_valid_q && m_bus.ready;
   assign fill_ack  = (state_q == cache_pkg::CACHE_FILL) && mem_ack;
   assign fill_last = fill_ack && (cnt_q == '1);
   assign wr_ack    = (state_q == cache_pkg::CACHE_WRITE) && mem_ack;

   //////////////////////////////////////////////////
   // Control FSM
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (i_reset) begin
         state_q     <= cache_pkg::CACHE_IDLE;
         valid_q     <= '0;
         cnt_q       <= '0;
         mem_valid_q <= 1'b0;
         o_ready     <= 1'b0;
      end else begin
         o_ready <= rd_hit || fill_last || wr_ack;   // Always a single pulse
         case (state_q)
            cache_pkg::CACHE_IDLE: begin
               if (rd_miss) begin
                  state_q          <= cache_pkg::CACHE_FILL;
                  valid_q[req_idx] <= 1'b0;   // Line is being replaced
                  cnt_q            <= '0;
                  mem_valid_q      <= 1'b1;
               end else if (wr_start) begin
                  state_q     <= cache_pkg::CACHE_WRITE;
                  mem_valid_q <= 1'b1;
               end
            end
            cache_pkg::CACHE_FILL: begin
               if (fill_ack) begin
                  cnt_q <= cnt_q + 1'b1;
                  if (fill_last) begin
                     valid_q[req_idx] <= 1'b1;   // Whole line present
                     mem_valid_q      <= 1'b0;
                     state_q          <= cache_pkg::CACHE_IDLE;
                  end
               end
            end
            cache_pkg::CACHE_WRITE: begin
               if (wr_ack) begin
                  mem_valid_q <= 1'b0;
                  state_q     <= cache_pkg::CACHE_IDLE;
               end
            end
            default: state_q <= cache_pkg::CACHE_IDLE;
         endcase
      end
   end

   //////////////////////////////////////////////////
   // Data path
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rd_hit) begin
         o_rdata <= data_q[{req_idx, req_off}];
      end

      // Fill starts at the line base
      if (rd_miss) begin
         mem_addr_q  <= {req_tag, req_idx, {`CACHE_WORD_OFF_W{1'b0}}};
         mem_wdata_q <= '0;
         mem_wstrb_q <= '0;
      end

      // Write goes out unchanged
      if (wr_start) begin
         mem_addr_q  <= i_addr;
         mem_wdata_q <= i_wdata;
         mem_wstrb_q <= i_wstrb;
      end

      if (fill_ack) begin
         data_q[{req_idx, cnt_q}] <= m_bus.rdata;
         if (cnt_q == req_off) begin
            o_rdata <= m_bus.rdata;   // Requested word on its beat
         end
         // Next ascending word, wraps harmlessly after the last
         mem_addr_q <= {req_tag, req_idx, cache_pkg::word_off_t'(cnt_q + 1'b1)};
         if (fill_last) begin
            tag_q[req_idx] <= req_tag;
         end
      end

      // Byte merge on write hit only
      if (wr_ack && hit) begin
         for (int b = 0; b < N_BYTES; b++) begin
            if (mem_wstrb_q[b]) begin
               data_q[{req_idx, req_off}][8*b +: 8] <= mem_wdata_q[8*b +: 8];
            end
         end
      end
   end

   // Memory bus driven straight from registers
   assign m_bus.valid = mem_valid_q;
   assign m_bus.addr  = mem_addr_q;
   assign m_bus.wdata = mem_wdata_q;
   assign m_bus.wstrb = mem_wstrb_q;

endmodule

// File: priority_interconnect.sv
`timescale 1ns/1ps

// Two masters onto one memory port
// Highest valid slot wins, instruction master in slot 1
module priority_interconnect (
   input  logic              clk,
   input  logic              i_reset,
   // Masters
   mem_bus_if.slave          s_instr,
   mem_bus_if.slave          s_data,
   // Memory port
   output logic              o_mem_valid,
   output cache_pkg::waddr_t o_mem_addr,
   output cache_pkg::word_t  o_mem_wdata,
   output cache_pkg::strb_t  o_mem_wstrb,
   input  cache_pkg::word_t  i_mem_rdata,
   input  logic              i_mem_ready
);

   localparam int N_MASTERS = 2;

   // Leading-one mask, keeps only the top set bit
   function automatic logic [N_MASTERS-1:0] lead_one(input logic [N_MASTERS-1:0] v);
      logic [N_MASTERS:0]   zeros_above;   // No valid at or above bit
      logic [N_MASTERS-1:0] mask;
      zeros_above[N_MASTERS] = 1'b1;
      for (int i = N_MASTERS - 1; i >= 0; i--) begin
         zeros_above[i] = zeros_above[i+1] & ~v[i];
         mask[i]        = zeros_above[i+1] & v[i];
      end
      return mask;
   endfunction

   //////////////////////////////////////////////////
   // Grant
   //////////////////////////////////////////////////

   logic [N_MASTERS-1:0] m_valid;
   logic [N_MASTERS-1:0] gnt;       // One-hot, or zero when idle
   logic [N_MASTERS-1:0] gnt_q;     // Held grant
   logic                 busy_q;    // Transaction open

   assign m_valid = {s_instr.valid, s_data.valid};
   assign gnt     = busy_q ? gnt_q : lead_one(m_valid);

   always_ff @(posedge clk) begin
      if (i_reset) begin
         busy_q <= 1'b0;
         gnt_q  <= '0;
      end else if (!busy_q) begin
         gnt_q <= gnt;
         // Zero-wait ready closes it in the same cycle
         busy_q <= o_mem_valid && !i_mem_ready;
      end else if (i_mem_ready) begin
         busy_q <= 1'b0;   // Released on the ack
      end
   end

   //////////////////////////////////////////////////
   // Request mux
   //////////////////////////////////////////////////

   always_comb begin
      o_mem_valid = |(gnt & m_valid);
      o_mem_addr  = '0;
      o_mem_wdata = '0;
      o_mem_wstrb = '0;
      if (gnt[1]) begin
         o_mem_addr  = s_instr.addr;
         o_mem_wdata = s_instr.wdata;
         o_mem_wstrb = s_instr.wstrb;
      end else if (gnt[0]) begin
         o_mem_addr  = s_data.addr;
         o_mem_wdata = s_data.wdata;
         o_mem_wstrb = s_data.wstrb;
      end
   end

   // Response goes to the granted master only
   assign s_instr.ready = gnt[1] & i_mem_ready;
   assign s_instr.rdata = gnt[1] ? i_mem_rdata : '0;
   assign s_data.ready  = gnt[0] & i_mem_ready;
   assign s_data.rdata  = gnt[0] ? i_mem_rdata : '0;

endmodule

// File: l2_id_system.sv
`timescale 1ns/1ps

// Instruction and data L1 caches sharing one memory port
module l2_id_system (
   input  logic              clk,
   input  logic              i_reset,
   // Instruction front port
   input  logic              i_instr_valid,
   input  cache_pkg::waddr_t i_instr_addr,
   input  cache_pkg::word_t  i_instr_wdata,
   input  cache_pkg::strb_t  i_instr_wstrb,
   output cache_pkg::word_t  o_instr_rdata,
   output logic              o_instr_ready,
   // Data front port
   input  logic              i_data_valid,
   input  cache_pkg::waddr_t i_data_addr,
   input  cache_pkg::word_t  i_data_wdata,
   input  cache_pkg::strb_t  i_data_wstrb,
   output cache_pkg::word_t  o_data_rdata,
   output logic              o_data_ready,
   // Shared memory port
   output logic              o_mem_valid,
   output cache_pkg::waddr_t o_mem_addr,
   output cache_pkg::word_t  o_mem_wdata,
   output cache_pkg::strb_t  o_mem_wstrb,
   input  cache_pkg::word_t  i_mem_rdata,
   input  logic              i_mem_ready
);

   //////////////////////////////////////////////////
   // Cache to interconnect buses
   //////////////////////////////////////////////////

   mem_bus_if instr_bus ();
   mem_bus_if data_bus ();

   l1_cache l1_instr (
      .clk     (clk),
      .i_reset (i_reset),
      .i_valid (i_instr_valid),
      .i_addr  (i_instr_addr),
      .i_wdata (i_instr_wdata),
      .i_wstrb (i_instr_wstrb),
      .o_rdata (o_instr_rdata),
      .o_ready (o_instr_ready),
      .m_bus   (instr_bus)
   );

   l1_cache l1_data (
      .clk     (clk),
      .i_reset (i_reset),
      .i_valid (i_data_valid),
      .i_addr  (i_data_addr),
      .i_wdata (i_data_wdata),
      .i_wstrb (i_data_wstrb),
      .o_rdata (o_data_rdata),
      .o_ready (o_data_ready),
      .m_bus   (data_bus)
   );

   // Instruction side has priority
   priority_interconnect cache_inter (
      .clk         (clk),
      .i_reset     (i_reset),
      .s_instr     (instr_bus),
      .s_data      (data_bus),
      .o_mem_valid (o_mem_valid),
      .o_mem_addr  (o_mem_addr),
      .o_mem_wdata (o_mem_wdata),
      .o_mem_wstrb (o_mem_wstrb),
      .i_mem_rdata (i_mem_rdata),
      .i_mem_ready (i_mem_ready)
   );

endmodule

// File: tb_l2_id_system_assert.sv
`timescale 1ns/1ps

// Protocol checks on the top level ports
module tb_l2_id_system_assert (
   input logic              clk,
   input logic              i_reset,
   input logic              i_instr_ready,
   input logic              i_data_ready,
   input logic              i_mem_valid,
   input cache_pkg::waddr_t i_mem_addr,
   input cache_pkg::word_t  i_mem_wdata,
   input cache_pkg::strb_t  i_mem_wstrb,
   input logic              i_mem_ready
);

   logic reset_q;        // Reset one cycle late
   int   fail_cnt = 0;   // Failed assertions so far

   always_ff @(posedge clk) begin
      reset_q <= i_reset;
   end

   //////////////////////////////////////////////////
   // Memory request held until acknowledged
   //////////////////////////////////////////////////

   mem_req_stable: assert property (@(posedge clk) disable iff (i_reset)
      i_mem_valid && !i_mem_ready |=> i_mem_valid && $stable(i_mem_addr)
         && $stable(i_mem_wdata) && $stable(i_mem_wstrb))
      else begin
         $error("memory request changed before ready");
         fail_cnt++;
      end

   // Outputs quiet once reset has been seen for a full cycle
   reset_quiet: assert property (@(posedge clk)
      i_reset && reset_q |-> !i_instr_ready && !i_data_ready && !i_mem_valid)
      else begin
         $error("output active during reset");
         fail_cnt++;
      end

   // Front readies are single pulses
   instr_ready_pulse: assert property (@(posedge clk) disable iff (i_reset)
      i_instr_ready |=> !i_instr_ready)
      else begin
         $error("instruction ready high two cycles");
         fail_cnt++;
      end

   data_ready_pulse: assert property (@(posedge clk) disable iff (i_reset)
      i_data_ready |=> !i_data_ready)
      else begin
         $error("data ready high two cycles");
         fail_cnt++;
      end

endmodule

bind l2_id_system tb_l2_id_system_assert l2_id_checks (
   .clk           (clk),
   .i_reset       (i_reset),
   .i_instr_ready (o_instr_ready),
   .i_data_ready  (o_data_ready),
   .i_mem_valid   (o_mem_valid),
   .i_mem_addr    (o_mem_addr),
   .i_mem_wdata   (o_mem_wdata),
   .i_mem_wstrb   (o_mem_wstrb),
   .i_mem_ready   (i_mem_ready)
);

// File: tb_l2_id_system.sv
`timescale 1ns/1ps

module tb_l2_id_system;

   localparam int CLK_PERIOD  = 4;
   localparam int N_TESTS     = 6;
   localparam int TEST_CYCLES = 200;
   localparam int WAIT_LIMIT  = 100;   // Cycles per front access

   logic              clk;
   logic              i_reset;
   logic              i_instr_valid;
   cache_pkg::waddr_t i_instr_addr;
   cache_pkg::word_t  i_instr_wdata;
   cache_pkg::strb_t  i_instr_wstrb;
   cache_pkg::word_t  o_instr_rdata;
   logic              o_instr_ready;
   logic              i_data_valid;
   cache_pkg::waddr_t i_data_addr;
   cache_pkg::word_t  i_data_wdata;
   cache_pkg::strb_t  i_data_wstrb;
   cache_pkg::word_t  o_data_rdata;
   logic              o_data_ready;
   logic              o_mem_valid;
   cache_pkg::waddr_t o_mem_addr;
   cache_pkg::word_t  o_mem_wdata;
   cache_pkg::strb_t  o_mem_wstrb;
   cache_pkg::word_t  i_mem_rdata;
   logic              i_mem_ready;

   l2_id_system UUT (.*);

   int errors       = 0;
   int tests_run    = 0;
   int tests_failed = 0;
   int assert_fails = 0;       // From the bound protocol checker
   int mem_valid_cycles = 0;   // Negedges with a memory request up

   //////////////////////////////////////////////////
   // Clock, LFSR and helpers
   //////////////////////////////////////////////////

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   logic [31:0] lfsr_q = 32'h11a8;

   // Galois LFSR stepped once per bit handed out
   function automatic logic [31:0] lfsr_take(input int nbits);
      logic [31:0] r;
      logic        b;
      r = '0;
      for (int i = 0; i < nbits; i++) begin
         b      = lfsr_q[0];
         lfsr_q = lfsr_q >> 1;
         if (b) lfsr_q = lfsr_q ^ 32'h8020_0003;
         r = {r[30:0], b};
      end
      return r;
   endfunction

   // Strobed bytes of new over old
   function automatic cache_pkg::word_t merge_bytes(input cache_pkg::word_t old_w,
         input cache_pkg::word_t new_w, input cache_pkg::strb_t strb);
      cache_pkg::word_t r;
      r = old_w;
      for (int b = 0; b < 4; b++) begin
         if (strb[b]) r[8*b +: 8] = new_w[8*b +: 8];
      end
      return r;
   endfunction

   task automatic check_word(input cache_pkg::word_t got, input cache_pkg::word_t exp,
         input string msg);
      if (got !== exp) begin
         $display("ERR @%0t ns: %s word %h expected %h", $time, msg, got, exp);
         errors++;
      end
   endtask

   task automatic check_addr(input cache_pkg::waddr_t got, input cache_pkg::waddr_t exp,
         input string msg);
      if (got !== exp) begin
         $display("ERR @%0t ns: %s addr %h expected %h", $time, msg, got, exp);
         errors++;
      end
   endtask

   task automatic check_strb(input cache_pkg::strb_t got, input cache_pkg::strb_t exp,
         input string msg);
      if (got !== exp) begin
         $display("ERR @%0t ns: %s strobe %b expected %b", $time, msg, got, exp);
         errors++;
      end
   endtask

   task automatic expect_count(input int got, input int exp, input string msg);
      if (got != exp) begin
         $display("ERR @%0t ns: %s count %0d expected %0d", $time, msg, got, exp);
         errors++;
      end
   endtask

   task automatic report_test(input string name, input int err0);
      tests_run++;
      if (errors != err0) tests_failed++;
      $display("test %-26s %s", name, (errors == err0) ? "ok" : "failed");
   endtask

   //////////////////////////////////////////////////
   // Memory model
   //////////////////////////////////////////////////

   cache_pkg::word_t  model_mem [256];
   cache_pkg::waddr_t log_addr  [$];   // One entry per served request
   cache_pkg::word_t  log_wdata [$];
   cache_pkg::strb_t  log_strb  [$];
   int                delay_cnt;
   bit                pending;

   always @(negedge clk) begin
      if (o_mem_valid === 1'b1) mem_valid_cycles++;
      if (i_reset) begin
         i_mem_ready = 1'b0;
         pending     = 1'b0;
      end else if (i_mem_ready) begin
         i_mem_ready = 1'b0;   // Handshake done at the last posedge
         pending     = 1'b0;
      end else if (o_mem_valid === 1'b1) begin
         if (!pending) begin
            delay_cnt = lfsr_take(2);   // 0 to 3 wait cycles
            pending   = 1'b1;
         end
         if (delay_cnt == 0) begin
            log_addr.push_back(o_mem_addr);
            log_wdata.push_back(o_mem_wdata);
            log_strb.push_back(o_mem_wstrb);
            i_mem_rdata = model_mem[o_mem_addr[7:0]];
            model_mem[o_mem_addr[7:0]] = merge_bytes(model_mem[o_mem_addr[7:0]],
                                                     o_mem_wdata, o_mem_wstrb);
            i_mem_ready = 1'b1;
         end else begin
            delay_cnt--;
         end
      end
   end

   //////////////////////////////////////////////////
   // Front port access
   //////////////////////////////////////////////////

   task automatic drive_front(input bit instr, input logic valid, input cache_pkg::waddr_t addr,
         input cache_pkg::word_t wdata, input cache_pkg::strb_t wstrb);
      if (instr) begin
         i_instr_valid = valid;
         i_instr_addr  = addr;
         i_instr_wdata = wdata;
         i_instr_wstrb = wstrb;
      end else begin
         i_data_valid = valid;
         i_data_addr  = addr;
         i_data_wdata = wdata;
         i_data_wstrb = wstrb;
      end
   endtask

   // One request held until its ready is seen
   task automatic front_access(input bit instr, input cache_pkg::waddr_t addr,
         input cache_pkg::word_t wdata, input cache_pkg::strb_t wstrb,
         output cache_pkg::word_t rdata, output int lat);
      bit done;
      done  = 1'b0;
      lat   = 0;
      rdata = '0;
      @(negedge clk);
      drive_front(instr, 1'b1, addr, wdata, wstrb);
      while (!done && lat < WAIT_LIMIT) begin
         @(negedge clk);
         lat++;
         if (instr ? o_instr_ready : o_data_ready) begin
            done  = 1'b1;
            rdata = instr ? o_instr_rdata : o_data_rdata;
         end
      end
      drive_front(instr, 1'b0, '0, '0, '0);
      if (!done) begin
         $display("Front port at address %h never answered, at %0t ns", addr, $time);
         errors++;
      end
   endtask

   //////////////////////////////////////////////////
   // Directed tests
   //////////////////////////////////////////////////

   task automatic read_miss_then_hit();
      int err0;
      int lat;
      int busy0;
      cache_pkg::word_t got;
      err0 = errors;
      front_access(1'b1, 30'h11, '0, '0, got, lat);
      check_word(got, model_mem[8'h11], "instr miss 0x11");
      busy0 = mem_valid_cycles;
      front_access(1'b1, 30'h13, '0, '0, got, lat);
      check_word(got, model_mem[8'h13], "instr hit 0x13");
      expect_count(lat, 1, "hit latency");
      expect_count(mem_valid_cycles - busy0, 0, "memory cycles on hit");
      report_test("read miss then hit", err0);
   endtask

   task automatic line_fill_order();
      int err0;
      int lat;
      int n0;
      cache_pkg::word_t got;
      err0 = errors;
      n0   = log_addr.size();
      front_access(1'b1, 30'h22, '0, '0, got, lat);
      check_word(got, model_mem[8'h22], "instr miss 0x22");
      expect_count(log_addr.size() - n0, 4, "fill reads");
      for (int k = 0; k < 4 && n0 + k < log_addr.size(); k++) begin
         check_addr(log_addr[n0+k], cache_pkg::waddr_t'(30'h20 + k), "fill beat");
         check_strb(log_strb[n0+k], 4'b0000, "fill beat");
      end
      report_test("line fill order", err0);
   endtask

   task automatic write_through_merge();
      int err0;
      int lat;
      int n0;
      int busy0;
      cache_pkg::word_t got;
      cache_pkg::word_t old_w;
      cache_pkg::word_t exp;
      err0 = errors;
      front_access(1'b0, 30'h31, '0, '0, got, lat);   // Bring the line in
      old_w = model_mem[8'h31];
      check_word(got, old_w, "data read 0x31");
      exp = merge_bytes(old_w, 32'hdead_beef, 4'b0110);
      n0  = log_addr.size();
      front_access(1'b0, 30'h31, 32'hdead_beef, 4'b0110, got, lat);
      expect_count(log_addr.size() - n0, 1, "write-through requests");
      if (log_addr.size() > n0) begin
         check_addr(log_addr[n0], 30'h31, "write-through");
         check_word(log_wdata[n0], 32'hdead_beef, "write-through");
         check_strb(log_strb[n0], 4'b0110, "write-through");
      end
      check_word(model_mem[8'h31], exp, "memory after write");
      busy0 = mem_valid_cycles;
      front_access(1'b0, 30'h31, '0, '0, got, lat);   // Must hit the merged line
      check_word(got, exp, "merged hit");
      expect_count(mem_valid_cycles - busy0, 0, "memory cycles on merged hit");
      report_test("write-through with merge", err0);
   endtask

   task automatic no_write_allocate();
      int err0;
      int lat;
      int n0;
      cache_pkg::word_t got;
      cache_pkg::word_t exp;
      err0 = errors;
      exp  = merge_bytes(model_mem[8'h45], 32'h5a5a_c3c3, 4'b1001);
      front_access(1'b0, 30'h45, 32'h5a5a_c3c3, 4'b1001, got, lat);
      n0 = log_addr.size();
      front_access(1'b0, 30'h45, '0, '0, got, lat);
      expect_count(log_addr.size() - n0, 4, "fill after write miss");
      check_word(got, exp, "read after write miss");
      report_test("no write allocate", err0);
   endtask

   task automatic arbitrate_misses();
      int err0;
      int n0;
      int cycles;
      bit instr_done;
      bit data_done;
      cache_pkg::word_t instr_got;
      cache_pkg::word_t data_got;
      err0       = errors;
      n0         = log_addr.size();
      cycles     = 0;
      instr_done = 1'b0;
      data_done  = 1'b0;
      @(negedge clk);
      drive_front(1'b1, 1'b1, 30'h56, '0, '0);   // Both misses in one cycle
      drive_front(1'b0, 1'b1, 30'h69, '0, '0);
      while (!(instr_done && data_done) && cycles < WAIT_LIMIT) begin
         @(negedge clk);
         cycles++;
         if (!instr_done && o_instr_ready) begin
            instr_done = 1'b1;
            instr_got  = o_instr_rdata;
            drive_front(1'b1, 1'b0, '0, '0, '0);
         end
         if (!data_done && o_data_ready) begin
            data_done = 1'b1;
            data_got  = o_data_rdata;
            drive_front(1'b0, 1'b0, '0, '0, '0);
         end
      end
      if (!(instr_done && data_done)) begin
         $display("Arbitration test did not get both readies, at %0t ns", $time);
         errors++;
      end
      expect_count(log_addr.size() - n0, 8, "arbitrated reads");
      if (log_addr.size() > n0 + 4) begin
         check_addr(log_addr[n0], 30'h54, "first granted request");
         check_addr(log_addr[n0+4], 30'h68, "data fill start");
      end
      check_word(instr_got, model_mem[8'h56], "instr after arbitration");
      check_word(data_got, model_mem[8'h69], "data after arbitration");
      report_test("arbitration", err0);
   endtask

   task automatic stale_instr_read();
      int err0;
      int lat;
      int busy0;
      cache_pkg::word_t got;
      cache_pkg::word_t old_w;
      err0  = errors;
      old_w = model_mem[8'h86];
      front_access(1'b1, 30'h86, '0, '0, got, lat);   // Line now in instr cache
      check_word(got, old_w, "instr read 0x86");
      front_access(1'b0, 30'h86, ~old_w, 4'b1111, got, lat);
      check_word(model_mem[8'h86], ~old_w, "memory after data write");
      busy0 = mem_valid_cycles;
      front_access(1'b1, 30'h86, '0, '0, got, lat);
      check_word(got, old_w, "stale instr word");
      expect_count(mem_valid_cycles - busy0, 0, "memory cycles on stale hit");
      report_test("no coherence", err0);
   endtask

   //////////////////////////////////////////////////
   // Main sequence and watchdog
   //////////////////////////////////////////////////

   initial begin
      i_reset = 1'b1;
      drive_front(1'b1, 1'b0, '0, '0, '0);
      drive_front(1'b0, 1'b0, '0, '0, '0);
      i_mem_rdata = '0;
      i_mem_ready = 1'b0;
      for (int i = 0; i < 256; i++) begin
         model_mem[i] = lfsr_take(32);
      end
      repeat (3) @(posedge clk);
      @(negedge clk);
      i_reset = 1'b0;
      read_miss_then_hit();
      line_fill_order();
      write_through_merge();
      no_write_allocate();
      arbitrate_misses();
      stale_instr_read();
      @(negedge clk);
      assert_fails = UUT.l2_id_checks.fail_cnt;
      $display("tests run %0d, failed %0d, errors %0d, assertion failures %0d",
               tests_run, tests_failed, errors, assert_fails);
      if (errors == 0 && assert_fails == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

   initial begin
      #(N_TESTS * TEST_CYCLES * CLK_PERIOD);
      $display("Watchdog expired, tests still running after %0d ns", $time);
      $display(">>> FAIL");
      $finish;
   end

endmodule

// File: src.f
+incdir+.
cache_pkg.sv
mem_bus_if.sv
l1_cache.sv
priority_interconnect.sv
l2_id_system.sv
tb_l2_id_system_assert.sv
tb_l2_id_system.sv
